// ==== src/cache_geom_pkg.sv ====
package cache_geom_pkg;

    // ======================================================================
    // Word and line geometry
    // ======================================================================
    localparam int XLEN       = 32;                      // Processor word width
    localparam int LINE_WORDS = 4;                       // Words per cache line
    localparam int LINE_W     = XLEN * LINE_WORDS;       // Line width in bits

    // Offset fields below the set index in | tag | set | word | byte |
    localparam int BYTE_OFF_W = $clog2(XLEN / 8);        // Byte within a word
    localparam int WORD_OFF_W = $clog2(LINE_WORDS);      // Word within a line
    localparam int LINE_OFF_W = BYTE_OFF_W + WORD_OFF_W; // Byte within a line

    // ======================================================================
    // Data types
    // ======================================================================
    typedef logic [XLEN-1:0]       word_t;     // One processor word
    typedef logic [XLEN/8-1:0]     byte_en_t;  // One enable per byte lane
    typedef logic [XLEN-1:0]       addr_t;     // Byte address
    typedef logic [LINE_W-1:0]     line_t;     // Whole cache line with word 0 in the low bits
    typedef logic [WORD_OFF_W-1:0] word_off_t; // Word index inside a line

endpackage

// ==== src/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    // ======================================================================
    // Controller FSM states
    // ======================================================================
    typedef enum logic [2:0] {
        INIT,     // Sweep all sets and clear valid and dirty
        IDLE,     // Wait for a processor strobe
        ANALYSIS, // Tag compare where a hit answers
        WB_MEM,   // Dirty victim on its way to memory
        WB_DONE,  // Write-back acknowledged
        RD_MEM,   // Line refill requested
        RD_DONE   // Commit the refill line and answer
    } ctrl_state_t;

    // Memory command on m_rw_o
    localparam logic MEM_READ  = 1'b0;
    localparam logic MEM_WRITE = 1'b1;

endpackage

// ==== src/word_merge.sv ====
module word_merge
    import cache_geom_pkg::*;
(
    input  line_t     line_i,        // Hit line or refill line
    input  word_off_t word_off_i,
    input  word_t     wr_word_i,
    input  byte_en_t  be_i,
    output word_t     rd_word_o,
    output line_t     merged_line_o
);

    word_t new_word;                 // Addressed word after the byte merge

    // Word k sits at line bits [k*XLEN +: XLEN]
    assign rd_word_o = line_i[word_off_i*XLEN +: XLEN];

    // Byte lanes
    always_comb
    begin
        for (int b = 0; b < XLEN / 8; b++)
        begin
            if (be_i[b])
                new_word[b*8 +: 8] = wr_word_i[b*8 +: 8];
            else
                new_word[b*8 +: 8] = rd_word_o[b*8 +: 8];   // Keep the old byte
        end
    end

    // Only the addressed word changes
    always_comb
    begin
        merged_line_o = line_i;
        merged_line_o[word_off_i*XLEN +: XLEN] = new_word;
    end

endmodule

// ==== src/fifo_victim.sv ====
module fifo_victim #(
    parameter int  N_WAYS = 4,
    parameter int  N_SETS = 16,
    localparam int IDX_W  = $clog2(N_SETS),
    localparam int WAY_W  = $clog2(N_WAYS)
)
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [IDX_W-1:0] set_idx_i,
    input  logic             refill_i,      // Line committed into the victim way
    output logic [WAY_W-1:0] victim_way_o   // Next way to replace in the indexed set
);

    logic [WAY_W-1:0] fifo_cnt [N_SETS];     // Oldest way per set

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
                fifo_cnt[s] <= '0;
        end
        else if (refill_i)
        begin
            if (fifo_cnt[set_idx_i] == WAY_W'(N_WAYS - 1))
                fifo_cnt[set_idx_i] <= '0;       // Wrap for any way count
            else
                fifo_cnt[set_idx_i] <= fifo_cnt[set_idx_i] + 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        victim_way_o <= fifo_cnt[set_idx_i];     // Same latency as the way arrays
    end

endmodule

// ==== src/dcache_ways.sv ====
module dcache_ways
    import cache_geom_pkg::*;
#(
    parameter int  N_WAYS = 4,
    parameter int  N_SETS = 16,
    localparam int IDX_W  = $clog2(N_SETS),
    localparam int TAG_W  = XLEN - IDX_W - LINE_OFF_W,
    localparam int WAY_W  = $clog2(N_WAYS)
)
(
    input  logic              clk_i,
    input  logic [IDX_W-1:0]  set_idx_i,
    input  logic [TAG_W-1:0]  tag_i,
    input  logic [N_WAYS-1:0] way_we_i,
    input  line_t             wr_line_i,
    input  logic              wr_dirty_i,
    input  logic              init_i,       // Clear valid and dirty of the indexed set
    input  logic [WAY_W-1:0]  victim_way_i,
    output logic              hit_o,
    output logic [WAY_W-1:0]  hit_way_o,
    output line_t             hit_line_o,
    output logic [TAG_W-1:0]  vic_tag_o,
    output logic              vic_dirty_o,
    output line_t             vic_line_o
);

    logic [TAG_W-1:0]  tag_mem   [N_WAYS][N_SETS];
    line_t             line_mem  [N_WAYS][N_SETS];
    logic [N_SETS-1:0] valid_mem [N_WAYS];          // Bit per set
    logic [N_SETS-1:0] dirty_mem [N_WAYS];
    logic [TAG_W-1:0]  tag_q     [N_WAYS];          // Synchronous read ports
    line_t             line_q    [N_WAYS];
    logic [N_WAYS-1:0] valid_q, dirty_q, way_hit;

    // Tag and line arrays read one cycle after the index
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (way_we_i[w])
            begin
                tag_mem[w][set_idx_i]  <= tag_i;
                line_mem[w][set_idx_i] <= wr_line_i;
            end
            tag_q[w]  <= tag_mem[w][set_idx_i];
            line_q[w] <= line_mem[w][set_idx_i];
        end
    end

    // Status bits where the init sweep has priority
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (init_i)
            begin
                valid_mem[w][set_idx_i] <= 1'b0;
                dirty_mem[w][set_idx_i] <= 1'b0;
            end
            else if (way_we_i[w])
            begin
                valid_mem[w][set_idx_i] <= 1'b1;
                dirty_mem[w][set_idx_i] <= wr_dirty_i;
            end
            valid_q[w] <= valid_mem[w][set_idx_i];
            dirty_q[w] <= dirty_mem[w][set_idx_i];
        end
    end

    // Hit detection over all ways
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            way_hit[w] = valid_q[w] && (tag_q[w] == tag_i);
            if (way_hit[w])
                hit_way_o = WAY_W'(w);               // At most one way matches
        end
    end

    assign hit_o       = |way_hit;
    assign hit_line_o  = line_q[hit_way_o];
    assign vic_tag_o   = tag_q[victim_way_i];
    assign vic_dirty_o = dirty_q[victim_way_i];
    assign vic_line_o  = line_q[victim_way_i];

endmodule

// ==== src/dcache_ctrl.sv ====
module dcache_ctrl
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;
#(
    parameter int  N_WAYS = 4,
    parameter int  N_SETS = 16,
    localparam int IDX_W  = $clog2(N_SETS),
    localparam int TAG_W  = XLEN - IDX_W - LINE_OFF_W,
    localparam int WAY_W  = $clog2(N_WAYS)
)
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              p_strobe_i,
    input  logic              p_rw_i,
    input  addr_t             p_addr_i,
    input  word_t             p_data_i,
    input  byte_en_t          p_be_i,
    output word_t             p_data_o,
    output logic              p_ready_o,
    output logic              m_strobe_o,
    output logic              m_rw_o,
    output addr_t             m_addr_o,
    output line_t             m_data_o,
    input  line_t             m_data_i,
    input  logic              m_ready_i,
    input  logic              hit_i,
    input  logic [WAY_W-1:0]  hit_way_i,
    input  logic [WAY_W-1:0]  victim_way_i,
    input  logic [TAG_W-1:0]  vic_tag_i,
    input  logic              vic_dirty_i,
    input  line_t             vic_line_i,
    input  line_t             hit_line_i,
    input  word_t             rd_word_i,     // Word picked from base_line_o
    input  line_t             merged_line_i, // base_line_o with the write applied
    output logic [IDX_W-1:0]  set_idx_o,
    output logic [TAG_W-1:0]  tag_o,
    output logic [N_WAYS-1:0] way_we_o,
    output line_t             wr_line_o,
    output logic              wr_dirty_o,
    output logic              init_o,
    output logic              refill_o,
    output line_t             base_line_o,
    output word_off_t         word_off_o,
    output word_t             wr_word_o,
    output byte_en_t          be_o
);

    ctrl_state_t      state_q, state_d;
    logic [IDX_W-1:0] init_cnt;                  // Set swept during INIT
    addr_t            req_addr;                  // Registered request
    logic             req_rw;
    word_t            req_data;
    byte_en_t         req_be;
    line_t            refill_line;               // Line returned by memory
    logic             enter_mem;                 // First cycle of WB_MEM or RD_MEM next

    // ======================================================================
    // FSM
    // ======================================================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= INIT;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        unique case (state_q)
            INIT:     if (init_cnt == IDX_W'(N_SETS - 1)) state_d = IDLE;
            IDLE:     if (p_strobe_i) state_d = ANALYSIS;
            ANALYSIS:
                if (hit_i)
                    state_d = IDLE;                  // Hit answered right here
                else
                    state_d = vic_dirty_i ? WB_MEM : RD_MEM;
            WB_MEM:   if (m_ready_i) state_d = WB_DONE;
            WB_DONE:  state_d = RD_MEM;
            RD_MEM:   if (m_ready_i) state_d = RD_DONE;
            RD_DONE:  state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            init_cnt <= '0;
        else if (state_q == INIT)
            init_cnt <= init_cnt + 1'b1;             // One set per cycle
    end

    // Request and refill capture
    always_ff @(posedge clk_i)
    begin
        if (state_q == IDLE && p_strobe_i)
        begin
            req_addr <= p_addr_i;
            req_rw   <= p_rw_i;
            req_data <= p_data_i;
            req_be   <= p_be_i;
        end
        if (state_q == RD_MEM && m_ready_i)
            refill_line <= m_data_i;
    end

    // ======================================================================
    // Memory request with one strobe per memory state
    // ======================================================================
    assign enter_mem = (state_d != state_q) && (state_d == WB_MEM || state_d == RD_MEM);

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            m_rw_o     <= MEM_READ;
        end
        else
        begin
            m_strobe_o <= enter_mem;
            if (enter_mem)
                m_rw_o <= (state_d == WB_MEM) ? MEM_WRITE : MEM_READ;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (enter_mem && state_d == WB_MEM)
        begin
            m_addr_o <= {vic_tag_i, set_idx_o, {LINE_OFF_W{1'b0}}};  // Victim line address
            m_data_o <= vic_line_i;
        end
        else if (enter_mem)
            m_addr_o <= {req_addr[XLEN-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
    end

    // ======================================================================
    // Processor answer and way update
    // ======================================================================
    assign p_ready_o = (state_q == ANALYSIS && hit_i) || state_q == RD_DONE;
    assign p_data_o  = (p_ready_o && !req_rw) ? rd_word_i : '0;

    // Strobe cycle indexes straight from the processor so ANALYSIS sees the set
    assign set_idx_o = (state_q == INIT) ? init_cnt :
                       (state_q == IDLE) ? p_addr_i[LINE_OFF_W +: IDX_W] :
                                           req_addr[LINE_OFF_W +: IDX_W];
    assign tag_o       = req_addr[XLEN-1 -: TAG_W];
    assign init_o      = (state_q == INIT);
    assign refill_o    = (state_q == RD_DONE);          // Advance the set's FIFO pointer
    assign base_line_o = (state_q == RD_DONE) ? refill_line : hit_line_i;
    assign word_off_o  = req_addr[BYTE_OFF_W +: WORD_OFF_W];
    assign wr_word_o   = req_data;
    assign be_o        = req_be;
    assign wr_line_o   = req_rw ? merged_line_i : refill_line;
    assign wr_dirty_o  = req_rw;                        // Any write leaves the line dirty

    always_comb
    begin
        for (int w = 0; w < N_WAYS; w++)
            way_we_o[w] = (state_q == ANALYSIS && hit_i && req_rw && hit_way_i == WAY_W'(w)) ||
                          (state_q == RD_DONE && victim_way_i == WAY_W'(w));
    end

endmodule

// ==== src/dcache_top.sv ====
module dcache_top
    import cache_geom_pkg::*;
#(
    parameter int  N_WAYS = 4,
    parameter int  N_SETS = 16,
    localparam int IDX_W  = $clog2(N_SETS),
    localparam int TAG_W  = XLEN - IDX_W - LINE_OFF_W,
    localparam int WAY_W  = $clog2(N_WAYS)
)
(
    input  logic     clk_i,
    input  logic     rst_i,
    // Processor side
    input  logic     p_strobe_i,    // One-cycle request pulse
    input  logic     p_rw_i,        // 0 read, 1 write
    input  addr_t    p_addr_i,
    input  word_t    p_data_i,
    input  byte_en_t p_be_i,
    output word_t    p_data_o,
    output logic     p_ready_o,     // One-cycle done pulse
    // Memory side
    output logic     m_strobe_o,
    output logic     m_rw_o,
    output addr_t    m_addr_o,      // Line aligned
    output line_t    m_data_o,
    input  line_t    m_data_i,
    input  logic     m_ready_i
);

    logic [IDX_W-1:0]  set_idx;
    logic [TAG_W-1:0]  tag, vic_tag;
    logic [N_WAYS-1:0] way_we;
    logic [WAY_W-1:0]  hit_way, victim_way;
    logic              wr_dirty, init, refill, hit, vic_dirty;
    line_t             wr_line, base_line, merged_line, hit_line, vic_line;
    word_off_t         word_off;
    word_t             wr_word, rd_word;
    byte_en_t          be;

    dcache_ctrl #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_ctrl (
        .clk_i, .rst_i, .p_strobe_i, .p_rw_i, .p_addr_i, .p_data_i, .p_be_i,
        .p_data_o, .p_ready_o, .m_strobe_o, .m_rw_o, .m_addr_o, .m_data_o,
        .m_data_i, .m_ready_i,
        .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
        .vic_tag_i(vic_tag), .vic_dirty_i(vic_dirty), .vic_line_i(vic_line),
        .hit_line_i(hit_line), .rd_word_i(rd_word), .merged_line_i(merged_line),
        .set_idx_o(set_idx), .tag_o(tag), .way_we_o(way_we), .wr_line_o(wr_line),
        .wr_dirty_o(wr_dirty), .init_o(init), .refill_o(refill),
        .base_line_o(base_line), .word_off_o(word_off), .wr_word_o(wr_word), .be_o(be)
    );

    dcache_ways #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_ways (
        .clk_i, .set_idx_i(set_idx), .tag_i(tag), .way_we_i(way_we),
        .wr_line_i(wr_line), .wr_dirty_i(wr_dirty), .init_i(init),
        .victim_way_i(victim_way), .hit_o(hit), .hit_way_o(hit_way),
        .hit_line_o(hit_line), .vic_tag_o(vic_tag), .vic_dirty_o(vic_dirty),
        .vic_line_o(vic_line)
    );

    fifo_victim #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_fifo (
        .clk_i, .rst_i, .set_idx_i(set_idx), .refill_i(refill), .victim_way_o(victim_way)
    );

    word_merge u_merge (
        .line_i(base_line), .word_off_i(word_off), .wr_word_i(wr_word), .be_i(be),
        .rd_word_o(rd_word), .merged_line_o(merged_line)
    );

endmodule

// ==== test/mem_model.sv ====
module mem_model
    import cache_geom_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  m_strobe_i,      // Request pulse from the cache
    input  logic  m_rw_i,          // 0 refill read, 1 write-back
    input  addr_t m_addr_i,        // Line aligned
    input  line_t m_data_i,
    output line_t m_data_o,
    output logic  m_ready_o,       // One-cycle answer
    output word_t wb_count_o,      // Write-back strobes seen
    output word_t rd_count_o       // Refill strobes seen
);

    timeunit 1ns;
    timeprecision 1ps;

    line_t       mem [addr_t];     // Only lines that were written back
    logic        busy;
    logic [3:0]  wait_cnt;         // Cycles left before the answer
    logic        pend_rw;
    addr_t       pend_addr;
    line_t       pend_data;
    logic [31:0] lcg_state;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Untouched memory holds its byte address with the upper half inverted
    function automatic line_t initial_line(input addr_t line_addr);
        line_t l;
        for (int k = 0; k < LINE_WORDS; k++)
            l[k*XLEN +: XLEN] = (line_addr + addr_t'(4 * k)) ^ 32'hFFFF_0000;
        return l;
    endfunction

    always @(posedge clk_i)
    begin : respond
        logic [31:0] nxt;
        if (rst_i)
        begin
            busy       <= 1'b0;
            m_ready_o  <= 1'b0;
            m_data_o   <= '0;
            wb_count_o <= '0;
            rd_count_o <= '0;
            lcg_state  <= 32'd9;             // Seed
        end
        else
        begin
            m_ready_o <= 1'b0;
            if (m_strobe_i && !busy)
            begin
                nxt        = lcg_next(lcg_state);
                lcg_state <= nxt;
                wait_cnt  <= {1'b0, nxt[18:16]} + 4'd1;  // 1 to 8 cycles
                busy      <= 1'b1;
                pend_rw   <= m_rw_i;
                pend_addr <= m_addr_i;
                pend_data <= m_data_i;
            end
            else if (busy && wait_cnt != 4'd1)
                wait_cnt <= wait_cnt - 4'd1;
            else if (busy)
            begin
                busy      <= 1'b0;
                m_ready_o <= 1'b1;
                if (pend_rw)
                begin
                    mem[pend_addr] = pend_data;
                    wb_count_o     <= wb_count_o + 1;
                end
                else
                begin
                    m_data_o   <= mem.exists(pend_addr) ? mem[pend_addr] : initial_line(pend_addr);
                    rd_count_o <= rd_count_o + 1;
                end
            end
        end
    end

endmodule

// ==== test/tb_dcache.sv ====
module tb_dcache
    import cache_geom_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    N_WAYS   = 4;
    localparam int    N_SETS   = 16;
    localparam int    FIELDS   = 5;          // Columns per stimulus line
    localparam int    MAX_OPS  = 64;
    localparam word_t END_MARK = '1;         // Left in entries the file does not fill

    logic     clk, rst;
    logic     p_strobe, p_rw, p_ready;
    addr_t    p_addr;
    word_t    p_wdata, p_rdata;
    byte_en_t p_be;
    logic     m_strobe, m_rw, m_ready;
    addr_t    m_addr;
    line_t    m_wline, m_rline;
    word_t    wb_count, rd_count;            // From the memory model

    word_t    stim [FIELDS*MAX_OPS];
    int       n_ops;
    int       checks;
    int       errors;

    // ======================================================================
    // DUT and memory
    // ======================================================================
    dcache_top #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) UUT (
        .clk_i(clk), .rst_i(rst),
        .p_strobe_i(p_strobe), .p_rw_i(p_rw), .p_addr_i(p_addr), .p_data_i(p_wdata),
        .p_be_i(p_be), .p_data_o(p_rdata), .p_ready_o(p_ready),
        .m_strobe_o(m_strobe), .m_rw_o(m_rw), .m_addr_o(m_addr), .m_data_o(m_wline),
        .m_data_i(m_rline), .m_ready_i(m_ready)
    );

    mem_model u_mem (
        .clk_i(clk), .rst_i(rst), .m_strobe_i(m_strobe), .m_rw_i(m_rw),
        .m_addr_i(m_addr), .m_data_i(m_wline), .m_data_o(m_rline),
        .m_ready_o(m_ready), .wb_count_o(wb_count), .rd_count_o(rd_count)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;                    // 4 ns period

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic compare(input string name, input word_t got, input word_t exp_val);
        checks++;
        if (got !== exp_val)
        begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp_val);
        end
    endtask

    // Strobe one processor request for a single cycle and wait for ready
    task automatic access(input logic rw, input addr_t addr, input word_t data,
                          input byte_en_t be, input word_t exp_val);
        @(posedge clk);
        #1;
        p_strobe = 1'b1;
        p_rw     = rw;
        p_addr   = addr;
        p_wdata  = data;
        p_be     = be;
        @(posedge clk);
        #1;
        p_strobe = 1'b0;
        do
            @(negedge clk);                  // Outputs settled mid-cycle
        while (!p_ready);
        if (!rw)
            compare("p_data_o", p_rdata, exp_val);
    endtask

    task automatic run_op(input int idx);
        word_t op;
        word_t exp_val;
        op      = stim[idx*FIELDS];
        exp_val = stim[idx*FIELDS + 4];
        case (op)
            32'd0, 32'd1:
                access(op[0], stim[idx*FIELDS + 1], stim[idx*FIELDS + 2],
                       stim[idx*FIELDS + 3][3:0], exp_val);
            32'd2:   compare("wb_count", wb_count, exp_val);
            32'd3:   compare("rd_count", rd_count, exp_val);
            default:
            begin
                errors++;
                $display("Unknown operation %0h on stimulus line %0d", op, idx);
            end
        endcase
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial
    begin
        rst      = 1'b1;
        p_strobe = 1'b0;
        p_rw     = 1'b0;
        p_addr   = '0;
        p_wdata  = '0;
        p_be     = '0;
        checks   = 0;
        errors   = 0;
        for (int i = 0; i < FIELDS * MAX_OPS; i++)
            stim[i] = END_MARK;
        $readmemh("test/dcache_stim.txt", stim);
        n_ops = 0;
        while (n_ops < MAX_OPS && stim[n_ops*FIELDS] != END_MARK)
            n_ops++;
        if (n_ops == 0)
        begin
            errors++;
            $display("No operations were read from the stimulus file");
        end

        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        // The cache stays silent on both sides through the INIT sweep
        repeat (2 * N_SETS)
        begin
            @(negedge clk);
            compare("p_ready_o", word_t'(p_ready), '0);
            compare("m_strobe_o", word_t'(m_strobe), '0);
        end

        for (int i = 0; i < n_ops; i++)
            run_op(i);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // Watchdog allows 40 cycles per operation on top of reset and INIT
    initial
    begin
        #1;
        repeat (10 + 2 * N_SETS + 40 * n_ops) @(posedge clk);
        $display("Timeout after %0t ns, the cache stopped answering", $time);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
src/cache_geom_pkg.sv
src/cache_ctrl_pkg.sv
src/word_merge.sv
src/fifo_victim.sv
src/dcache_ways.sv
src/dcache_ctrl.sv
src/dcache_top.sv
test/mem_model.sv
test/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_dcache -f all.f -o sim_dcache \
    && ./obj_dir/sim_dcache > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

// ==== test/dcache_stim.txt ====
// Columns: op address data byte_enable expected_value (all hex)
// op 0 read, 1 write, 2 check write-back count, 3 check refill count
0 00000104 00000000 0 FFFF0104
0 00000104 00000000 0 FFFF0104
0 00000108 00000000 0 FFFF0108
3 00000000 00000000 0 00000001
1 00000104 11223344 5 00000000
0 00000104 00000000 0 FF220144
3 00000000 00000000 0 00000001
1 00000218 CAFEBABE C 00000000
0 00000218 00000000 0 CAFE0218
0 00000214 00000000 0 FFFF0214
3 00000000 00000000 0 00000002
1 00001030 A1A1A1A1 F 00000000
1 00002030 B2B2B2B2 F 00000000
1 00003030 C3C3C3C3 F 00000000
1 00004030 D4D4D4D4 F 00000000
2 00000000 00000000 0 00000000
1 00005030 E5E5E5E5 F 00000000
2 00000000 00000000 0 00000001
0 00001030 00000000 0 A1A1A1A1
0 00001034 00000000 0 FFFF1034
0 00005030 00000000 0 E5E5E5E5
2 00000000 00000000 0 00000002
3 00000000 00000000 0 00000008
